//--- hw/corePkg.sv
package corePkg;

    localparam int dataWidth = 32;
    localparam int regAddrWidth = 5;
    localparam logic [dataWidth-1:0] resetVector = 32'hBFC00000;

    // major opcodes
    localparam logic [5:0] opSpecial = 6'b000000;
    localparam logic [5:0] opJ = 6'b000010;
    localparam logic [5:0] opBeq = 6'b000100;
    localparam logic [5:0] opBne = 6'b000101;
    localparam logic [5:0] opAddiu = 6'b001001;
    localparam logic [5:0] opSlti = 6'b001010;
    localparam logic [5:0] opSltiu = 6'b001011;
    localparam logic [5:0] opAndi = 6'b001100;
    localparam logic [5:0] opOri = 6'b001101;
    localparam logic [5:0] opXori = 6'b001110;
    localparam logic [5:0] opLui = 6'b001111;

    // SPECIAL funct field
    localparam logic [5:0] fnSll = 6'b000000;
    localparam logic [5:0] fnSrl = 6'b000010;
    localparam logic [5:0] fnAddu = 6'b100001;
    localparam logic [5:0] fnSubu = 6'b100011;
    localparam logic [5:0] fnAnd = 6'b100100;
    localparam logic [5:0] fnOr = 6'b100101;
    localparam logic [5:0] fnXor = 6'b100110;
    localparam logic [5:0] fnNor = 6'b100111;
    localparam logic [5:0] fnSlt = 6'b101010;
    localparam logic [5:0] fnSltu = 6'b101011;

    typedef enum logic [3:0] {
        aluAdd, aluSub, aluAnd, aluOr, aluXor, aluNor,
        aluSlt, aluSltu, aluSll, aluSrl, aluLui
    } aluOpE;

    typedef enum logic {fwdReg, fwdWb} fwdSelE;

    typedef struct packed {
        logic [5:0] opcode;
        logic [regAddrWidth-1:0] rs;
        logic [regAddrWidth-1:0] rt;
        logic [regAddrWidth-1:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } rTypeS;

    typedef struct packed {
        logic [5:0] opcode;
        logic [regAddrWidth-1:0] rs;
        logic [regAddrWidth-1:0] rt;
        logic [15:0] imm16;
    } iTypeS;

    // one word under two field layouts; the j target is iType[25:0]
    typedef union packed {
        rTypeS rType;
        iTypeS iType;
    } instrU;

    typedef struct packed {
        aluOpE aluOp;
        logic useImm;
        logic regWrite;
        logic isBranch;
        logic branchNe;
        logic useShamt;
        logic [regAddrWidth-1:0] dest;
    } ctrlS;

    typedef struct packed {
        logic valid;
        logic [dataWidth-1:0] pc;
        logic [regAddrWidth-1:0] rs;
        logic [regAddrWidth-1:0] rt;
        logic [dataWidth-1:0] rsValue;
        logic [dataWidth-1:0] rtValue;
        logic [dataWidth-1:0] imm;
        logic [4:0] shamt;
        ctrlS ctrl;
    } idExS;

    typedef struct packed {
        logic valid;
        logic [dataWidth-1:0] pc;
        logic regWrite;
        logic [regAddrWidth-1:0] dest;
        logic [dataWidth-1:0] result;
    } exWbS;

endpackage

//--- hw/fetchStage.sv
`timescale 1ns/1ps

module fetchStage (
    input logic clk,
    input logic rstN,
    input logic stall,
    input logic jumpD,
    input logic [corePkg::dataWidth-1:0] jumpTarget,
    input logic branchTaken,
    input logic [corePkg::dataWidth-1:0] branchTarget,
    output logic [corePkg::dataWidth-1:0] pc,
    output logic instEn
);
    import corePkg::*;

    logic [dataWidth-1:0] pcNext;

    // EX branch is older than the D jump, so it wins
    always_comb begin
        if (branchTaken) begin
            pcNext = branchTarget;
        end else if (jumpD) begin
            pcNext = jumpTarget;
        end else begin
            pcNext = pc + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            pc <= resetVector;
            instEn <= 1'b0;
        end else begin
            instEn <= 1'b1;
            if (instEn && !stall) begin
                pc <= pcNext; // hold on icache stall and until fetch is enabled
            end
        end
    end

endmodule

//--- hw/instrDecoder.sv
`timescale 1ns/1ps

module instrDecoder (
    input corePkg::instrU instr,
    input logic [corePkg::dataWidth-1:0] pcPlus4,
    output corePkg::ctrlS ctrl,
    output logic [corePkg::dataWidth-1:0] imm,
    output logic jumpD,
    output logic [corePkg::dataWidth-1:0] jumpTarget
);
    import corePkg::*;

    function automatic aluOpE immAluOp(input logic [5:0] op);
        case (op)
            opSlti: return aluSlt;
            opSltiu: return aluSltu;
            opAndi: return aluAnd;
            opOri: return aluOr;
            opXori: return aluXor;
            opLui: return aluLui;
            default: return aluAdd;
        endcase
    endfunction

    always_comb begin
        ctrl = '0;
        ctrl.aluOp = aluAdd;
        ctrl.dest = instr.rType.rd;
        jumpD = 1'b0;
        case (instr.rType.opcode)
            opSpecial: begin
                ctrl.regWrite = 1'b1;
                ctrl.useShamt = (instr.rType.funct == fnSll) || (instr.rType.funct == fnSrl);
                case (instr.rType.funct)
                    fnSll: ctrl.aluOp = aluSll;
                    fnSrl: ctrl.aluOp = aluSrl;
                    fnAddu: ctrl.aluOp = aluAdd;
                    fnSubu: ctrl.aluOp = aluSub;
                    fnAnd: ctrl.aluOp = aluAnd;
                    fnOr: ctrl.aluOp = aluOr;
                    fnXor: ctrl.aluOp = aluXor;
                    fnNor: ctrl.aluOp = aluNor;
                    fnSlt: ctrl.aluOp = aluSlt;
                    fnSltu: ctrl.aluOp = aluSltu;
                    default: ctrl.regWrite = 1'b0; // unknown funct acts as a no-op
                endcase
            end
            opAddiu, opSlti, opSltiu, opAndi, opOri, opXori, opLui: begin
                ctrl.useImm = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.dest = instr.iType.rt;
                ctrl.aluOp = immAluOp(instr.iType.opcode);
            end
            opBeq: ctrl.isBranch = 1'b1;
            opBne: begin
                ctrl.isBranch = 1'b1;
                ctrl.branchNe = 1'b1;
            end
            opJ: jumpD = 1'b1;
            default: ;
        endcase
    end

    // logical ops zero extend and lui goes to the upper half
    always_comb begin
        case (instr.iType.opcode)
            opAndi, opOri, opXori: imm = {16'h0000, instr.iType.imm16};
            opLui: imm = {instr.iType.imm16, 16'h0000};
            default: imm = {{16{instr.iType.imm16[15]}}, instr.iType.imm16};
        endcase
    end

    assign jumpTarget = {pcPlus4[31:28], instr.iType[25:0], 2'b00};

endmodule

//--- hw/regFile.sv
`timescale 1ns/1ps

module regFile (
    input logic clk,
    input logic we,
    input logic [corePkg::regAddrWidth-1:0] wa,
    input logic [corePkg::dataWidth-1:0] wd,
    input logic [corePkg::regAddrWidth-1:0] ra1,
    input logic [corePkg::regAddrWidth-1:0] ra2,
    output logic [corePkg::dataWidth-1:0] rd1,
    output logic [corePkg::dataWidth-1:0] rd2
);
    import corePkg::*;

    logic [dataWidth-1:0] regs [1:31]; // $0 has no storage

    always_ff @(posedge clk) begin
        if (we && wa != '0) begin
            regs[wa] <= wd;
        end
    end

    // write-through so ID sees the value WB writes this cycle
    function automatic logic [dataWidth-1:0] readPort(input logic [regAddrWidth-1:0] ra);
        if (ra == '0) begin
            return '0;
        end else if (we && wa == ra) begin
            return wd;
        end
        return regs[ra];
    endfunction

    always_comb begin
        rd1 = readPort(ra1);
        rd2 = readPort(ra2);
    end

endmodule

//--- hw/hazardUnit.sv
`timescale 1ns/1ps

module hazardUnit (
    input logic iCacheStall,
    input logic jumpD,
    input logic branchTaken,
    input corePkg::idExS idEx,
    input corePkg::exWbS exWb,
    output corePkg::fwdSelE fwdA,
    output corePkg::fwdSelE fwdB,
    output logic stallF,
    output logic flushD,
    output logic flushE
);
    import corePkg::*;

    logic wbWrites;

    assign wbWrites = exWb.valid && exWb.regWrite && (exWb.dest != '0);

    // only WB can be one ahead of EX; two ahead comes through the regfile
    assign fwdA = (wbWrites && exWb.dest == idEx.rs) ? fwdWb : fwdReg;
    assign fwdB = (wbWrites && exWb.dest == idEx.rt) ? fwdWb : fwdReg;

    // whole pipe freezes on a fetch miss
    assign stallF = iCacheStall;

    // a stalled redirect stays in place and fires once the stall clears
    assign flushD = (branchTaken || jumpD) && !stallF;
    assign flushE = branchTaken && !stallF;

endmodule

//--- hw/executeStage.sv
`timescale 1ns/1ps

module executeStage (
    input corePkg::idExS idEx,
    input corePkg::exWbS wbFwd,
    input corePkg::fwdSelE fwdA,
    input corePkg::fwdSelE fwdB,
    output corePkg::exWbS exOut,
    output logic branchTaken,
    output logic [corePkg::dataWidth-1:0] branchTarget
);
    import corePkg::*;

    logic [dataWidth-1:0] rsVal;
    logic [dataWidth-1:0] rtVal;
    logic [dataWidth-1:0] srcA;
    logic [dataWidth-1:0] srcB;
    logic [dataWidth-1:0] aluResult;

    assign rsVal = (fwdA == fwdWb) ? wbFwd.result : idEx.rsValue;
    assign rtVal = (fwdB == fwdWb) ? wbFwd.result : idEx.rtValue;

    // shifts take the amount from srcA
    assign srcA = idEx.ctrl.useShamt ? {{(dataWidth-5){1'b0}}, idEx.shamt} : rsVal;
    assign srcB = idEx.ctrl.useImm ? idEx.imm : rtVal;

    always_comb begin
        case (idEx.ctrl.aluOp)
            aluAdd: aluResult = srcA + srcB;
            aluSub: aluResult = srcA - srcB;
            aluAnd: aluResult = srcA & srcB;
            aluOr: aluResult = srcA | srcB;
            aluXor: aluResult = srcA ^ srcB;
            aluNor: aluResult = ~(srcA | srcB);
            aluSlt: aluResult = {{(dataWidth-1){1'b0}}, $signed(srcA) < $signed(srcB)};
            aluSltu: aluResult = {{(dataWidth-1){1'b0}}, srcA < srcB};
            aluSll: aluResult = srcB << srcA[4:0];
            aluSrl: aluResult = srcB >> srcA[4:0];
            aluLui: aluResult = srcB; // imm already shifted in decode
            default: aluResult = '0;
        endcase
    end

    // beq/bne on forwarded operands
    assign branchTaken = idEx.valid && idEx.ctrl.isBranch
                         && ((rsVal == rtVal) ^ idEx.ctrl.branchNe);
    assign branchTarget = idEx.pc + 32'd4 + {idEx.imm[dataWidth-3:0], 2'b00};

    always_comb begin
        exOut.valid = idEx.valid;
        exOut.pc = idEx.pc;
        exOut.regWrite = idEx.ctrl.regWrite;
        exOut.dest = idEx.ctrl.dest;
        exOut.result = aluResult;
    end

endmodule

//--- hw/mipsCore.sv
`timescale 1ns/1ps

module mipsCore (
    input logic clk,
    input logic rstN,
    output logic [corePkg::dataWidth-1:0] pc,
    output logic instEn,
    input logic [corePkg::dataWidth-1:0] instr,
    input logic iCacheStall,
    output logic [corePkg::dataWidth-1:0] debugWbPc,
    output logic [3:0] debugWbRfWen,
    output logic [corePkg::regAddrWidth-1:0] debugWbRfWnum,
    output logic [corePkg::dataWidth-1:0] debugWbRfWdata
);
    import corePkg::*;

    logic stallF, flushD, flushE;
    logic ifIdValid;
    logic [dataWidth-1:0] ifIdPc;
    instrU ifIdInstr;
    ctrlS ctrlD;
    logic [dataWidth-1:0] immD, pcPlus4D, jumpTargetD, rsValueD, rtValueD;
    logic jumpRawD, jumpD;
    idExS idExNext, idEx;
    exWbS exNext, exWb;
    fwdSelE fwdA, fwdB;
    logic branchTaken;
    logic [dataWidth-1:0] branchTarget;
    logic rfWe;

    fetchStage fetch0 (
        .clk(clk), .rstN(rstN),
        .stall(stallF),
        .jumpD(jumpD), .jumpTarget(jumpTargetD),
        .branchTaken(branchTaken), .branchTarget(branchTarget),
        .pc(pc), .instEn(instEn)
    );

    // IF/ID
    always_ff @(posedge clk) begin
        if (!rstN) begin
            ifIdValid <= 1'b0;
        end else if (!stallF) begin
            ifIdValid <= instEn & ~flushD;
        end
    end

    always_ff @(posedge clk) begin
        if (!stallF) begin
            ifIdPc <= pc;
            ifIdInstr <= instr;
        end
    end

    assign pcPlus4D = ifIdPc + 32'd4;
    assign jumpD = jumpRawD & ifIdValid; // bubbles never redirect

    instrDecoder decoder0 (
        .instr(ifIdInstr), .pcPlus4(pcPlus4D),
        .ctrl(ctrlD), .imm(immD),
        .jumpD(jumpRawD), .jumpTarget(jumpTargetD)
    );

    regFile regFile0 (
        .clk(clk),
        .we(rfWe), .wa(exWb.dest), .wd(exWb.result),
        .ra1(ifIdInstr.rType.rs), .ra2(ifIdInstr.rType.rt),
        .rd1(rsValueD), .rd2(rtValueD)
    );

    always_comb begin
        idExNext.valid = ifIdValid & ~flushE;
        idExNext.pc = ifIdPc;
        idExNext.rs = ifIdInstr.rType.rs;
        idExNext.rt = ifIdInstr.rType.rt;
        idExNext.rsValue = rsValueD;
        idExNext.rtValue = rtValueD;
        idExNext.imm = immD;
        idExNext.shamt = ifIdInstr.rType.shamt;
        idExNext.ctrl = ctrlD;
    end

    // ID/EX and EX/WB
    always_ff @(posedge clk) begin
        if (!rstN) begin
            idEx.valid <= 1'b0;
            exWb.valid <= 1'b0;
        end else if (!stallF) begin
            idEx <= idExNext;
            exWb <= exNext;
        end
    end

    executeStage execute0 (
        .idEx(idEx), .wbFwd(exWb),
        .fwdA(fwdA), .fwdB(fwdB),
        .exOut(exNext),
        .branchTaken(branchTaken), .branchTarget(branchTarget)
    );

    hazardUnit hazard0 (
        .iCacheStall(iCacheStall),
        .jumpD(jumpD), .branchTaken(branchTaken),
        .idEx(idEx), .exWb(exWb),
        .fwdA(fwdA), .fwdB(fwdB),
        .stallF(stallF), .flushD(flushD), .flushE(flushE)
    );

    // retire only on the edge the WB register actually advances
    assign rfWe = exWb.valid & exWb.regWrite & (exWb.dest != '0) & ~stallF;

    assign debugWbPc = exWb.pc;
    assign debugWbRfWen = {4{rfWe}};
    assign debugWbRfWnum = exWb.dest;
    assign debugWbRfWdata = exWb.result;

endmodule

//--- test/coreTb.sv
`timescale 1ns/1ps

module coreTb;
    import corePkg::*;

    typedef struct packed {
        logic [31:0] pc;
        logic [4:0] dest;
        logic [31:0] value;
    } retireS;

    logic clk;
    logic rstN;
    logic iCacheStall;
    logic [31:0] pc;
    logic instEn;
    logic [31:0] instr;
    logic [31:0] debugWbPc;
    logic [3:0] debugWbRfWen;
    logic [4:0] debugWbRfWnum;
    logic [31:0] debugWbRfWdata;

    logic [31:0] rom [0:255];
    logic [31:0] pcOffset;
    retireS expQ [$];
    int wp;
    int errors = 0;
    int tests = 0;
    int failedTests = 0;
    bit randomStall = 1'b0;
    logic [31:0] stallRng = 32'he37477e8;

    mipsCore dut_i (
        .clk(clk), .rstN(rstN),
        .pc(pc), .instEn(instEn), .instr(instr), .iCacheStall(iCacheStall),
        .debugWbPc(debugWbPc), .debugWbRfWen(debugWbRfWen),
        .debugWbRfWnum(debugWbRfWnum), .debugWbRfWdata(debugWbRfWdata)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // zero word (sll $0) outside the program
    assign pcOffset = pc - resetVector;
    assign instr = (pcOffset < 32'd1024) ? rom[pcOffset[9:2]] : 32'h0;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    function automatic logic [31:0] rWord(input logic [5:0] fn, input logic [4:0] rd,
                                           input logic [4:0] rs, input logic [4:0] rt,
                                           input logic [4:0] sh);
        return {opSpecial, rs, rt, rd, sh, fn};
    endfunction

    function automatic logic [31:0] iWord(input logic [5:0] op, input logic [4:0] rs,
                                           input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] jWord(input int idx);
        logic [31:0] a;
        a = resetVector + 32'(idx * 4);
        return {opJ, a[27:2]};
    endfunction

    function automatic logic [5:0] rFunct(input int k);
        case (k)
            0: return fnSll;
            1: return fnSrl;
            2: return fnAddu;
            3: return fnSubu;
            4: return fnAnd;
            5: return fnOr;
            6: return fnXor;
            7: return fnNor;
            8: return fnSlt;
            default: return fnSltu;
        endcase
    endfunction

    function automatic logic [5:0] iOpcode(input int k);
        case (k)
            0: return opAddiu;
            1: return opSlti;
            2: return opSltiu;
            3: return opAndi;
            4: return opOri;
            5: return opXori;
            default: return opLui;
        endcase
    endfunction

    task automatic emit(input logic [31:0] word);
        rom[8'(wp)] = word;
        wp++;
    endtask

    task automatic startProgram();
        int i;
        rstN = 1'b0; // core held in reset while the ROM changes
        for (i = 0; i < 256; i++) begin
            rom[8'(i)] = 32'h0;
        end
        wp = 0;
    endtask

    // every R and I op on random operands plus two writes to $0
    task automatic buildAluProgram();
        logic [31:0] r;
        int k;
        startProgram();
        r = 32'he37477e8;
        for (k = 1; k <= 4; k++) begin
            r = xorshift(r);
            emit(iWord(opLui, 5'd0, 5'(k), r[31:16]));
            emit(iWord(opOri, 5'(k), 5'(k), r[15:0]));
        end
        for (k = 0; k < 10; k++) begin
            r = xorshift(r);
            emit(rWord(rFunct(k), 5'(k + 5), 5'(r[1:0] + 1), 5'(r[3:2] + 1),
                       (k < 2) ? r[8:4] : 5'd0));
        end
        for (k = 0; k < 7; k++) begin
            r = xorshift(r);
            emit(iWord(iOpcode(k), 5'(r[1:0] + 1), 5'(k + 15), r[31:16]));
        end
        emit(rWord(fnAddu, 5'd0, 5'd1, 5'd2, 5'd0));
        emit(iWord(opAddiu, 5'd3, 5'd0, 16'h1234));
        emit(jWord(wp)); // halt
    endtask

    // architectural model without delay slots; a jump to itself ends the run
    task automatic runModel();
        logic [31:0] regs [0:31];
        logic [31:0] mpc, off, ir, a, b, se, val, next;
        logic wr;
        logic [4:0] d;
        retireS rec;
        int steps;
        regs[0] = 32'h0;
        mpc = resetVector;
        for (steps = 0; steps < 1000; steps++) begin
            off = mpc - resetVector;
            ir = (off < 32'd1024) ? rom[off[9:2]] : 32'h0;
            a = regs[ir[25:21]];
            b = regs[ir[20:16]];
            se = {{16{ir[15]}}, ir[15:0]};
            next = mpc + 32'd4;
            wr = 1'b1;
            d = ir[20:16];
            val = 32'h0;
            case (ir[31:26])
                opSpecial: begin
                    d = ir[15:11];
                    case (ir[5:0])
                        fnSll: val = b << ir[10:6];
                        fnSrl: val = b >> ir[10:6];
                        fnAddu: val = a + b;
                        fnSubu: val = a - b;
                        fnAnd: val = a & b;
                        fnOr: val = a | b;
                        fnXor: val = a ^ b;
                        fnNor: val = ~(a | b);
                        fnSlt: val = 32'($signed(a) < $signed(b));
                        fnSltu: val = 32'(a < b);
                        default: wr = 1'b0;
                    endcase
                end
                opAddiu: val = a + se;
                opSlti: val = 32'($signed(a) < $signed(se));
                opSltiu: val = 32'(a < se);
                opAndi: val = a & {16'h0, ir[15:0]};
                opOri: val = a | {16'h0, ir[15:0]};
                opXori: val = a ^ {16'h0, ir[15:0]};
                opLui: val = {ir[15:0], 16'h0};
                opBeq, opBne: begin
                    wr = 1'b0;
                    if ((a == b) == (ir[31:26] == opBeq)) begin
                        next = mpc + 32'd4 + {se[29:0], 2'b00};
                    end
                end
                opJ: begin
                    wr = 1'b0;
                    next = {next[31:28], ir[25:0], 2'b00};
                end
                default: wr = 1'b0;
            endcase
            if (wr && d != 5'd0) begin
                regs[d] = val;
                rec.pc = mpc;
                rec.dest = d;
                rec.value = val;
                expQ.push_back(rec);
            end
            if (next == mpc) begin
                break;
            end
            mpc = next;
        end
    endtask

    task automatic runTest(input string name, input bit stalls);
        int errBefore;
        int cyc;
        int writes;
        errBefore = errors;
        runModel();
        writes = expQ.size();
        for (cyc = 0; cyc < 3; cyc++) begin
            @(posedge clk);
        end
        @(negedge clk);
        assert (pc == resetVector && instEn == 1'b0 && debugWbRfWen == 4'h0) else begin
            $display("Fail at %0t: reset state pc %h instEn %b wen %h", $time, pc, instEn,
                     debugWbRfWen);
            errors++;
        end
        randomStall = stalls;
        @(posedge clk);
        #1;
        rstN = 1'b1;
        @(negedge clk);
        assert (pc == resetVector) else begin
            $display("Fail at %0t: pc %h after reset", $time, pc);
            errors++;
        end
        for (cyc = 0; cyc < 2000 && expQ.size() != 0; cyc++) begin
            @(posedge clk);
        end
        if (expQ.size() != 0) begin
            $display("timeout: %s still waits for %0d of %0d writes after 2000 cycles",
                     name, expQ.size(), writes);
            errors++;
            expQ.delete();
        end
        for (cyc = 0; cyc < 20; cyc++) begin
            @(posedge clk); // core spins on the halt jump and stray writes show here
        end
        @(negedge clk);
        randomStall = 1'b0;
        @(posedge clk);
        #1;
        tests++;
        if (errors != errBefore) begin
            failedTests++;
        end
        $display("%s: %0d writes, %s", name, writes, (errors == errBefore) ? "ok" : "failed");
    endtask

    always @(posedge clk) begin
        #1;
        stallRng = xorshift(stallRng);
        iCacheStall = randomStall && stallRng[1:0] == 2'b00; // about one cycle in four
    end

    // every reported write must be the next one the model expects
    always @(negedge clk) begin
        retireS head;
        if (rstN && debugWbRfWen != 4'h0) begin
            assert (debugWbRfWen == 4'hF) else begin
                $display("Fail at %0t: debugWbRfWen %h", $time, debugWbRfWen);
                errors++;
            end
            assert (!iCacheStall) else begin
                $display("a write was reported at %0t while the fetch was stalled", $time);
                errors++;
            end
            assert (debugWbRfWnum != 5'd0) else begin
                $display("a write to register zero was reported at %0t", $time);
                errors++;
            end
            assert (expQ.size() != 0) else begin
                $display("unexpected write to r%0d at %0t after the last expected one",
                         debugWbRfWnum, $time);
                errors++;
            end
            if (expQ.size() != 0) begin
                head = expQ.pop_front();
                assert (debugWbPc == head.pc && debugWbRfWnum == head.dest
                        && debugWbRfWdata == head.value) else begin
                    $display("Fail at %0t: got pc %h r%0d=%h, expected pc %h r%0d=%h", $time,
                             debugWbPc, debugWbRfWnum, debugWbRfWdata, head.pc, head.dest,
                             head.value);
                    errors++;
                end
            end
        end
    end

    initial begin
        rstN = 1'b0;
        iCacheStall = 1'b0;

        startProgram();
        emit(jWord(0));
        runTest("after reset", 1'b0);

        buildAluProgram();
        runTest("alu results", 1'b0);

        // distance one and two dependencies
        startProgram();
        emit(iWord(opAddiu, 5'd0, 5'd1, 16'd5));
        emit(iWord(opAddiu, 5'd1, 5'd2, 16'd7));
        emit(rWord(fnAddu, 5'd3, 5'd1, 5'd2, 5'd0));
        emit(rWord(fnSubu, 5'd4, 5'd3, 5'd1, 5'd0));
        emit(rWord(fnSll, 5'd5, 5'd0, 5'd4, 5'd3));
        emit(rWord(fnOr, 5'd6, 5'd5, 5'd4, 5'd0));
        emit(rWord(fnXor, 5'd7, 5'd4, 5'd6, 5'd0));
        emit(iWord(opAddiu, 5'd1, 5'd1, 16'd1));
        emit(rWord(fnAddu, 5'd8, 5'd1, 5'd1, 5'd0));
        emit(jWord(wp));
        runTest("forwarding", 1'b0);

        startProgram();
        emit(iWord(opAddiu, 5'd0, 5'd1, 16'd3));
        emit(iWord(opAddiu, 5'd0, 5'd2, 16'd0));
        emit(iWord(opAddiu, 5'd0, 5'd3, 16'd3));
        emit(iWord(opBeq, 5'd1, 5'd3, 16'd2)); // taken
        emit(iWord(opAddiu, 5'd0, 5'd10, 16'd10));
        emit(iWord(opAddiu, 5'd0, 5'd11, 16'd11));
        emit(iWord(opBne, 5'd1, 5'd2, 16'd2)); // taken
        emit(iWord(opAddiu, 5'd0, 5'd12, 16'd12));
        emit(iWord(opAddiu, 5'd0, 5'd13, 16'd13));
        emit(iWord(opBeq, 5'd1, 5'd2, 16'd2));
        emit(iWord(opAddiu, 5'd0, 5'd14, 16'd14));
        emit(iWord(opBne, 5'd1, 5'd3, 16'd2));
        emit(iWord(opAddiu, 5'd0, 5'd15, 16'd15));
        emit(iWord(opAddiu, 5'd2, 5'd2, 16'd5)); // loop body runs three times
        emit(iWord(opAddiu, 5'd1, 5'd1, 16'hFFFF));
        emit(iWord(opBne, 5'd1, 5'd0, 16'hFFFD));
        emit(iWord(opAddiu, 5'd0, 5'd16, 16'd16));
        emit(jWord(wp));
        runTest("branches", 1'b0);

        startProgram();
        emit(iWord(opAddiu, 5'd0, 5'd1, 16'd1));
        emit(jWord(3));
        emit(iWord(opAddiu, 5'd0, 5'd2, 16'd2));
        emit(iWord(opAddiu, 5'd1, 5'd3, 16'd3));
        emit(jWord(7));
        emit(iWord(opAddiu, 5'd0, 5'd4, 16'd4));
        emit(iWord(opAddiu, 5'd0, 5'd5, 16'd5));
        emit(iWord(opAddiu, 5'd3, 5'd6, 16'd6));
        emit(jWord(wp));
        runTest("jumps", 1'b0);

        buildAluProgram();
        runTest("fetch stall", 1'b1);

        $display("%0d tests, %0d failed, %0d errors", tests, failedTests, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- compile.f
hw/corePkg.sv
hw/fetchStage.sv
hw/instrDecoder.sv
hw/regFile.sv
hw/hazardUnit.sv
hw/executeStage.sv
hw/mipsCore.sv
test/coreTb.sv

//--- Makefile
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps -f compile.f \
		--top-module coreTb -Mdir obj_dir -o coreTb
	@out=$$(./obj_dir/coreTb); echo "$$out"; echo "$$out" | grep -q '^RESULT: PASS$$'

clean:
	rm -rf obj_dir
